// ==== design/sdram_geom_pkg.sv ====
// SDRAM geometry types
`default_nettype none

package sdram_geom_pkg;

  // Device geometry
  localparam int BA_W      = 2;
  localparam int ROW_W     = 11;
  localparam int COL_W     = 8;
  localparam int DQ_W      = 16;
  localparam int NUM_BANKS = 1 << BA_W;

  typedef logic [BA_W-1:0]  ba_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [COL_W-1:0] col_t;
  typedef logic [DQ_W-1:0]  dq_t;

  // Address pins carry a full row during ACT
  typedef logic [ROW_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== design/sdram_cmd_pkg.sv ====
// SDRAM command encoding
`default_nettype none

package sdram_cmd_pkg;

  // Pin order is {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_t;

  typedef enum logic {
    BANK_IDLE   = 1'b0,
    BANK_ACTIVE = 1'b1
  } bank_state_t;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_REF_PRE = 2'd1,
    ST_REF     = 2'd2
  } sched_state_t;

  // A10 high on PRE closes every bank
  localparam int AP_BIT = 10;

endpackage

`default_nettype wire

// ==== design/sdram_timer_if.sv ====
// Timer load and status bundle
`timescale 1ns/1ps
`default_nettype none

interface sdram_timer_if
  import sdram_geom_pkg::*;
();

  // Load strobes, one cycle wide
  logic [NUM_BANKS-1:0] act_ld;
  logic [NUM_BANKS-1:0] pre_ld;
  logic                 ref_ld;

  // Expired flags
  logic [NUM_BANKS-1:0] rcd_done;
  logic [NUM_BANKS-1:0] rp_done;
  logic [NUM_BANKS-1:0] ras_done;
  logic                 rc_done;

  modport fsm (
    output act_ld, pre_ld, ref_ld,
    input  rcd_done, rp_done, ras_done, rc_done
  );

  modport timers (
    input  act_ld, pre_ld, ref_ld,
    output rcd_done, rp_done, ras_done, rc_done
  );

endinterface

`default_nettype wire

// ==== design/sdram_bank_timers.sv ====
// Bank and row cycle timers
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_timers
  import sdram_geom_pkg::*;
#(
  parameter int T_RCD = 3,
  parameter int T_RP  = 3,
  parameter int T_RAS = 6,
  parameter int T_RC  = 8
)
(
  input  logic          clk_i,
  input  logic          rst_ni,
  sdram_timer_if.timers tmr
);

  // Three counters per bank, then one shared tRC counter on top
  localparam int NT    = 3 * NUM_BANKS + 1;
  localparam int T_MAX = (T_RCD > T_RP) ? ((T_RCD > T_RAS) ? ((T_RCD > T_RC) ? T_RCD : T_RC)
                                                           : ((T_RAS > T_RC) ? T_RAS : T_RC))
                                        : ((T_RP > T_RAS)  ? ((T_RP > T_RC) ? T_RP : T_RC)
                                                           : ((T_RAS > T_RC) ? T_RAS : T_RC));
  localparam int CNT_W = $clog2(T_MAX + 1);

  logic [NT-1:0] ld;
  logic [NT-1:0] done;

  // tRC restarts on any ACT as well as on REF
  assign ld = {(|tmr.act_ld) | tmr.ref_ld, tmr.act_ld, tmr.pre_ld, tmr.act_ld};

  assign tmr.rcd_done = done[0 +: NUM_BANKS];
  assign tmr.rp_done  = done[NUM_BANKS +: NUM_BANKS];
  assign tmr.ras_done = done[2*NUM_BANKS +: NUM_BANKS];
  assign tmr.rc_done  = done[NT-1];

  //////////////////////////////////////////////////////////////////////
  // Down-counters
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NT; i++)
  begin : gen_cnt
    localparam int T_LD = (i < NUM_BANKS)   ? T_RCD :
                          (i < 2*NUM_BANKS) ? T_RP  :
                          (i < 3*NUM_BANKS) ? T_RAS : T_RC;
    // Loaded one short so the next command may land exactly T cycles later
    localparam logic [CNT_W-1:0] LD_VAL = CNT_W'((T_LD > 0) ? T_LD - 1 : 0);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        cnt     <= '0;
        done[i] <= 1'b1;
      end
      else if (ld[i])
      begin
        cnt     <= LD_VAL;
        done[i] <= (T_LD <= 1);
      end
      else if (!done[i])
      begin
        cnt     <= cnt - 1'b1;
        done[i] <= (cnt == CNT_W'(1));
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sdram_refresh_ctrl.sv ====
// Auto-refresh request generator
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_ctrl
#(
  parameter int T_REFI = 200
)
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic ref_pending_o
);

  localparam int            IW     = $clog2(T_REFI + 1);
  localparam logic [IW-1:0] RELOAD = IW'(T_REFI - 1);

  logic [IW-1:0] interval_q;
  logic          tick;
  logic [2:0]    pend_q;

  assign tick = (interval_q == '0);

  // Interval counter, one tick every T_REFI cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      interval_q <= RELOAD;
    else if (tick)
      interval_q <= RELOAD;
    else
      interval_q <= interval_q - 1'b1;
  end

  // Pending count, saturates at seven
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_q <= '0;
    else
    begin
      case ({tick, ref_issued_i && (|pend_q)})
        2'b10:
          if (!(&pend_q))
            pend_q <= pend_q + 1'b1;
        2'b01:
          pend_q <= pend_q - 1'b1;
        default: ;
      endcase
    end
  end

  assign ref_pending_o = |pend_q;

endmodule

`default_nettype wire

// ==== design/sdram_cmd_fsm.sv ====
// SDRAM command scheduler FSM
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_fsm
  import sdram_geom_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rd_req_i,
  input  logic       wr_req_i,
  input  ba_t        req_ba_i,
  input  row_t       req_row_i,
  input  col_t       req_col_i,
  input  dq_t        wr_data_i,
  input  logic       ref_pending_i,
  output logic       ref_issued_o,
  output logic       rd_issued_o,
  output logic       req_rdy_o,
  output sdram_cmd_t sdram_cmd_o,
  output ba_t        sdram_ba_o,
  output addr_t      sdram_addr_o,
  output dq_t        sdram_dq_o,
  output logic       sdram_dqoe_o,
  sdram_timer_if.fsm tmr
);

  sched_state_t         state_q;
  sched_state_t         state_d;
  bank_state_t          bank_st_q  [NUM_BANKS];
  row_t                 bank_row_q [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_open;
  logic                 req_valid;
  logic                 req_hit;
  sdram_cmd_t           cmd_d;
  ba_t                  ba_d;
  addr_t                addr_d;

  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
      bank_open[b] = (bank_st_q[b] == BANK_ACTIVE);
  end

  // Mask the request in the cycle it is acknowledged
  assign req_valid = (rd_req_i | wr_req_i) & ~req_rdy_o;
  assign req_hit   = bank_open[req_ba_i] && (bank_row_q[req_ba_i] == req_row_i);

  //////////////////////////////////////////////////////////////////////
  // Command decision
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    cmd_d      = CMD_NOP;
    ba_d       = sdram_ba_o;
    addr_d     = sdram_addr_o;
    tmr.act_ld = '0;
    tmr.pre_ld = '0;
    tmr.ref_ld = 1'b0;

    case (state_q)
      ST_IDLE:
      begin
        if (ref_pending_i)
          state_d = (|bank_open) ? ST_REF_PRE : ST_REF;
        else if (req_valid)
        begin
          // Bank lines are ignored by the device on NOP
          ba_d = req_ba_i;
          if (req_hit)
          begin
            if (tmr.rcd_done[req_ba_i])
            begin
              cmd_d  = wr_req_i ? CMD_WR : CMD_RD;
              addr_d = addr_t'(req_col_i);
            end
          end
          else if (!bank_open[req_ba_i])
          begin
            if (tmr.rp_done[req_ba_i] && tmr.rc_done)
            begin
              cmd_d                = CMD_ACT;
              addr_d               = req_row_i;
              tmr.act_ld[req_ba_i] = 1'b1;
            end
          end
          // Row miss, close the bank first
          else if (tmr.ras_done[req_ba_i])
          begin
            cmd_d                = CMD_PRE;
            addr_d[AP_BIT]       = 1'b0;
            tmr.pre_ld[req_ba_i] = 1'b1;
          end
        end
      end

      ST_REF_PRE:
      begin
        if (&tmr.ras_done)
        begin
          cmd_d          = CMD_PRE;
          addr_d[AP_BIT] = 1'b1;
          tmr.pre_ld     = '1;
          state_d        = ST_REF;
        end
      end

      ST_REF:
      begin
        if ((&tmr.rp_done) && tmr.rc_done)
        begin
          cmd_d      = CMD_REF;
          tmr.ref_ld = 1'b1;
          state_d    = ST_IDLE;
        end
      end

      default:
        state_d = ST_IDLE;
    endcase
  end

  // Count drops at the same edge the REF is registered
  assign ref_issued_o = tmr.ref_ld;
  assign rd_issued_o  = (sdram_cmd_o == CMD_RD);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ST_IDLE;
      sdram_cmd_o  <= CMD_NOP;
      req_rdy_o    <= 1'b0;
      sdram_dqoe_o <= 1'b0;
      for (int b = 0; b < NUM_BANKS; b++)
        bank_st_q[b] <= BANK_IDLE;
    end
    else
    begin
      state_q      <= state_d;
      sdram_cmd_o  <= cmd_d;
      req_rdy_o    <= (cmd_d == CMD_RD) || (cmd_d == CMD_WR);
      sdram_dqoe_o <= (cmd_d == CMD_WR);
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        if (tmr.pre_ld[b])
          bank_st_q[b] <= BANK_IDLE;
        else if (tmr.act_ld[b])
          bank_st_q[b] <= BANK_ACTIVE;
      end
    end
  end

  // Address, write data and open rows
  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= ba_d;
    sdram_addr_o <= addr_d;
    if (cmd_d == CMD_WR)
      sdram_dq_o <= wr_data_i;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (tmr.act_ld[b])
        bank_row_q[b] <= req_row_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/sdram_rd_tracker.sv ====
// Read data return path
`timescale 1ns/1ps
`default_nettype none

module sdram_rd_tracker
  import sdram_geom_pkg::*;
#(
  parameter int CL = 2
)
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rd_issued_i,
  input  dq_t  sdram_dq_i,
  output dq_t  rd_data_o,
  output logic rd_valid_o
);

  // One token per RD in flight
  logic [CL-1:0] cas_pipe;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cas_pipe   <= '0;
      rd_valid_o <= 1'b0;
    end
    else
    begin
      cas_pipe[0] <= rd_issued_i;
      for (int i = 1; i < CL; i++)
        cas_pipe[i] <= cas_pipe[i-1];
      rd_valid_o <= cas_pipe[CL-1];
    end
  end

  // DQ is valid on the pins as the token leaves
  always_ff @(posedge clk_i)
  begin
    if (cas_pipe[CL-1])
      rd_data_o <= sdram_dq_i;
  end

endmodule

`default_nettype wire

// ==== design/sdram_sched_top.sv ====
// SDRAM scheduler top level
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_top
  import sdram_geom_pkg::*;
  import sdram_cmd_pkg::*;
#(
  parameter int T_RCD  = 3,
  parameter int T_RP   = 3,
  parameter int T_RAS  = 6,
  parameter int T_RC   = 8,
  parameter int T_REFI = 200,
  parameter int CL     = 2
)
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rd_req_i,
  input  logic       wr_req_i,
  input  ba_t        req_ba_i,
  input  row_t       req_row_i,
  input  col_t       req_col_i,
  input  dq_t        wr_data_i,
  output logic       req_rdy_o,
  output dq_t        rd_data_o,
  output logic       rd_valid_o,
  output sdram_cmd_t sdram_cmd_o,
  output ba_t        sdram_ba_o,
  output addr_t      sdram_addr_o,
  input  dq_t        sdram_dq_i,
  output dq_t        sdram_dq_o,
  output logic       sdram_dqoe_o
);

  logic ref_pending;
  logic ref_issued;
  logic rd_issued;

  sdram_timer_if tmr_if ();

  sdram_bank_timers #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RAS (T_RAS),
    .T_RC  (T_RC)
  ) i_timers (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tmr    (tmr_if.timers)
  );

  sdram_refresh_ctrl #(
    .T_REFI (T_REFI)
  ) i_refresh (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ref_issued_i  (ref_issued),
    .ref_pending_o (ref_pending)
  );

  sdram_cmd_fsm i_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .wr_req_i      (wr_req_i),
    .req_ba_i      (req_ba_i),
    .req_row_i     (req_row_i),
    .req_col_i     (req_col_i),
    .wr_data_i     (wr_data_i),
    .ref_pending_i (ref_pending),
    .ref_issued_o  (ref_issued),
    .rd_issued_o   (rd_issued),
    .req_rdy_o     (req_rdy_o),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o),
    .sdram_dq_o    (sdram_dq_o),
    .sdram_dqoe_o  (sdram_dqoe_o),
    .tmr           (tmr_if.fsm)
  );

  sdram_rd_tracker #(
    .CL (CL)
  ) i_rd_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_issued_i (rd_issued),
    .sdram_dq_i  (sdram_dq_i),
    .rd_data_o   (rd_data_o),
    .rd_valid_o  (rd_valid_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
  parameter int HALF_NS = 2
)
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== verif/tb_checker.sv ====
// Scheduler protocol checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import sdram_geom_pkg::*;
  import sdram_cmd_pkg::*;
#(
  parameter int T_RCD  = 3,
  parameter int T_RP   = 3,
  parameter int T_RAS  = 6,
  parameter int T_RC   = 8,
  parameter int T_REFI = 200,
  parameter int CL     = 2
)
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_rdy_i,
  input  dq_t        rd_data_i,
  input  logic       rd_valid_i,
  input  sdram_cmd_t cmd_i,
  input  ba_t        ba_i,
  input  addr_t      addr_i,
  input  dq_t        dq_i,
  input  logic       dqoe_i,
  // Request currently held on the DUT inputs
  input  logic       hold_vld_i,
  input  ba_t        hold_ba_i,
  input  row_t       hold_row_i,
  input  logic       exp_stb_i,
  input  dq_t        exp_rdata_i,
  input  ba_t        exp_ba_i,
  input  row_t       exp_row_i,
  input  col_t       exp_col_i,
  input  dq_t        exp_wdata_i,
  output int         err_cnt_o,
  output int         ref_cnt_o,
  output int         rd_cnt_o
);

  // Longest legal distance between two REF commands
  localparam int REF_GAP = T_REFI + 2 * (T_RAS + T_RP + T_RCD + T_RC) + 8;

  int   cyc;
  int   rst_cyc;
  int   last_ref;
  int   gap_base;
  logic open_q  [NUM_BANKS];
  row_t row_q   [NUM_BANKS];
  int   act_cyc [NUM_BANKS];
  int   pre_cyc [NUM_BANKS];
  int   rd_cyc_q [$];
  dq_t  rd_exp_q [$];

  initial
  begin
    err_cnt_o = 0;
    ref_cnt_o = 0;
    rd_cnt_o  = 0;
    rst_cyc   = 0;
  end

  task automatic flag_error(input string msg);
    err_cnt_o++;
    $display("ERR %0t %s", $time, msg);
  endtask

  // Close one bank after PRE, checking tRAS first
  task automatic close_bank(input int b);
    if (cyc - act_cyc[b] < T_RAS)
      flag_error($sformatf("PRE to bank %0d only %0d cycles after ACT", b, cyc - act_cyc[b]));
    open_q[b]  = 1'b0;
    pre_cyc[b] = cyc;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Command tracking
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin : watch
    int  rcyc;
    dq_t rexp;
    if (!rst_ni)
    begin
      rst_cyc++;
      cyc      = 0;
      gap_base = 0;
      last_ref = -T_RC;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        open_q[b]  = 1'b0;
        act_cyc[b] = -T_RAS;
        pre_cyc[b] = -T_RP;
      end
      // First edge may still see unreset flops
      if (rst_cyc > 1 && (cmd_i != CMD_NOP || req_rdy_i || rd_valid_i || dqoe_i))
        flag_error("outputs active during reset");
    end
    else
    begin
      cyc++;
      if (exp_stb_i)
        rd_exp_q.push_back(exp_rdata_i);
      case (cmd_i)
        CMD_NOP: ;
        CMD_ACT:
        begin
          if (open_q[ba_i])
            flag_error($sformatf("ACT to open bank %0d", ba_i));
          if (cyc - pre_cyc[ba_i] < T_RP)
            flag_error($sformatf("ACT to bank %0d violates tRP", ba_i));
          if (cyc - last_ref < T_RC)
            flag_error("ACT within tRC of REF");
          if (!hold_vld_i || ba_i != hold_ba_i || row_t'(addr_i) != hold_row_i)
            flag_error($sformatf("ACT bank %0d row %h, held request bank %0d row %h",
                                 ba_i, row_t'(addr_i), hold_ba_i, hold_row_i));
          open_q[ba_i]  = 1'b1;
          row_q[ba_i]   = row_t'(addr_i);
          act_cyc[ba_i] = cyc;
        end
        CMD_RD, CMD_WR:
        begin
          if (!open_q[ba_i])
            flag_error($sformatf("access to idle bank %0d", ba_i));
          else if (row_q[ba_i] != exp_row_i)
            flag_error($sformatf("open row %h, request row %h", row_q[ba_i], exp_row_i));
          if (cyc - act_cyc[ba_i] < T_RCD)
            flag_error($sformatf("access to bank %0d violates tRCD", ba_i));
          if (!req_rdy_i)
            flag_error("no req_rdy with RD/WR");
          if (ba_i != exp_ba_i || col_t'(addr_i) != exp_col_i)
            flag_error($sformatf("bank %0d col %h, expected bank %0d col %h",
                                 ba_i, col_t'(addr_i), exp_ba_i, exp_col_i));
          if (cmd_i == CMD_WR && (!dqoe_i || dq_i != exp_wdata_i))
            flag_error($sformatf("WR oe %b data %h, expected %h", dqoe_i, dq_i, exp_wdata_i));
          if (cmd_i == CMD_RD)
            rd_cyc_q.push_back(cyc);
        end
        CMD_PRE:
        begin
          if (addr_i[AP_BIT])
          begin
            for (int b = 0; b < NUM_BANKS; b++)
            begin
              if (open_q[b])
                close_bank(b);
            end
          end
          else if (!open_q[ba_i])
            flag_error($sformatf("PRE to idle bank %0d", ba_i));
          else
          begin
            // Only a row miss of the held request may close a bank
            if (!hold_vld_i || ba_i != hold_ba_i || row_q[ba_i] == hold_row_i)
              flag_error($sformatf("PRE to bank %0d without a row miss", ba_i));
            close_bank(int'(ba_i));
          end
        end
        CMD_REF:
        begin
          for (int b = 0; b < NUM_BANKS; b++)
          begin
            if (open_q[b])
              flag_error($sformatf("REF with bank %0d open", b));
            if (cyc - pre_cyc[b] < T_RP)
              flag_error("REF violates tRP");
          end
          if (cyc - last_ref < T_RC)
            flag_error("REF within tRC of REF");
          last_ref = cyc;
          gap_base = cyc;
          ref_cnt_o++;
        end
        default:
          flag_error($sformatf("illegal command %b", cmd_i));
      endcase

      if (req_rdy_i && cmd_i != CMD_RD && cmd_i != CMD_WR)
        flag_error("req_rdy without RD/WR");
      if (dqoe_i && cmd_i != CMD_WR)
        flag_error("dqoe outside WR");
      if (cyc - gap_base > REF_GAP)
      begin
        flag_error("refresh interval exceeded");
        gap_base = cyc;
      end

      // Read return, exactly CL+1 cycles after RD
      if (rd_cyc_q.size() > 0 && rd_cyc_q[0] + CL + 1 < cyc)
      begin
        flag_error("read valid missing");
        void'(rd_cyc_q.pop_front());
      end
      if (rd_valid_i)
      begin
        if (rd_cyc_q.size() == 0 || rd_exp_q.size() == 0)
          flag_error("read valid without a read");
        else
        begin
          rcyc = rd_cyc_q.pop_front();
          rexp = rd_exp_q.pop_front();
          rd_cnt_o++;
          if (cyc != rcyc + CL + 1)
            flag_error($sformatf("read valid %0d cycles after RD", cyc - rcyc));
          if (rd_data_i != rexp)
            flag_error($sformatf("read data %h, expected %h", rd_data_i, rexp));
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
// Scheduler testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import sdram_geom_pkg::*;
  import sdram_cmd_pkg::*;
#(
  parameter int T_RCD  = 3,
  parameter int T_RP   = 3,
  parameter int T_RAS  = 6,
  parameter int T_RC   = 8,
  parameter int T_REFI = 200,
  parameter int CL     = 2
)
();

  localparam int MAX_OPS = 64;
  localparam int TAIL    = T_REFI + 2 * T_RC;

  logic       clk;
  logic       rst_ni;
  logic       rd_req;
  logic       wr_req;
  ba_t        req_ba;
  row_t       req_row;
  col_t       req_col;
  dq_t        wr_data;
  dq_t        sdram_dq;
  logic       req_rdy;
  dq_t        rd_data;
  logic       rd_valid;
  sdram_cmd_t sdram_cmd;
  ba_t        sdram_ba;
  addr_t      sdram_addr;
  dq_t        sdram_dq_out;
  logic       sdram_dqoe;

  logic       exp_stb;
  dq_t        exp_rdata;
  ba_t        exp_ba;
  row_t       exp_row;
  col_t       exp_col;
  dq_t        exp_wdata;
  int         chk_errs;
  int         ref_cnt;
  int         rd_cnt;

  // Trace contents
  logic       tr_rd   [MAX_OPS];
  ba_t        tr_ba   [MAX_OPS];
  row_t       tr_row  [MAX_OPS];
  col_t       tr_col  [MAX_OPS];
  dq_t        tr_data [MAX_OPS];
  int         n_ops;
  int         n_rd;
  int         idx;
  int         tb_errs;
  int         cyc_cnt;
  int         limit;

  // Read data due on DQ, slot 0 is this cycle
  logic       slot_vld [CL+1];
  dq_t        slot_dq  [CL+1];

  tb_clkgen i_clkgen (.clk_o(clk));

  sdram_sched_top #(
    .T_RCD (T_RCD), .T_RP (T_RP), .T_RAS (T_RAS),
    .T_RC (T_RC), .T_REFI (T_REFI), .CL (CL)
  ) i_dut (
    .clk_i (clk), .rst_ni (rst_ni),
    .rd_req_i (rd_req), .wr_req_i (wr_req),
    .req_ba_i (req_ba), .req_row_i (req_row), .req_col_i (req_col),
    .wr_data_i (wr_data), .req_rdy_o (req_rdy),
    .rd_data_o (rd_data), .rd_valid_o (rd_valid),
    .sdram_cmd_o (sdram_cmd), .sdram_ba_o (sdram_ba), .sdram_addr_o (sdram_addr),
    .sdram_dq_i (sdram_dq), .sdram_dq_o (sdram_dq_out), .sdram_dqoe_o (sdram_dqoe)
  );

  tb_checker #(
    .T_RCD (T_RCD), .T_RP (T_RP), .T_RAS (T_RAS),
    .T_RC (T_RC), .T_REFI (T_REFI), .CL (CL)
  ) i_checker (
    .clk_i (clk), .rst_ni (rst_ni),
    .req_rdy_i (req_rdy), .rd_data_i (rd_data), .rd_valid_i (rd_valid),
    .cmd_i (sdram_cmd), .ba_i (sdram_ba), .addr_i (sdram_addr),
    .dq_i (sdram_dq_out), .dqoe_i (sdram_dqoe),
    .hold_vld_i (rd_req | wr_req), .hold_ba_i (req_ba), .hold_row_i (req_row),
    .exp_stb_i (exp_stb), .exp_rdata_i (exp_rdata), .exp_ba_i (exp_ba),
    .exp_row_i (exp_row), .exp_col_i (exp_col), .exp_wdata_i (exp_wdata),
    .err_cnt_o (chk_errs), .ref_cnt_o (ref_cnt), .rd_cnt_o (rd_cnt)
  );

  task automatic load_trace();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    int         ba;
    int         row;
    int         col;
    int         data;
    n_ops = 0;
    n_rd  = 0;
    fd    = $fopen("verif/sched_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file verif/sched_trace.txt");
      tb_errs++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;
      n = $sscanf(line, "%c %h %h %h %h", op, ba, row, col, data);
      if (n == 5 && n_ops < MAX_OPS)
      begin
        tr_rd[n_ops]   = (op == "R");
        tr_ba[n_ops]   = ba_t'(ba);
        tr_row[n_ops]  = row_t'(row);
        tr_col[n_ops]  = col_t'(col);
        tr_data[n_ops] = dq_t'(data);
        if (op == "R")
          n_rd++;
        n_ops++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_request();
    if (idx < n_ops)
    begin
      rd_req  = tr_rd[idx];
      wr_req  = !tr_rd[idx];
      req_ba  = tr_ba[idx];
      req_row = tr_row[idx];
      req_col = tr_col[idx];
      wr_data = tr_rd[idx] ? '0 : tr_data[idx];
    end
    else
    begin
      rd_req = 1'b0;
      wr_req = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (rst_ni)
    begin
      exp_stb = 1'b0;
      for (int i = 0; i < CL; i++)
      begin
        slot_vld[i] = slot_vld[i+1];
        slot_dq[i]  = slot_dq[i+1];
      end
      slot_vld[CL] = 1'b0;
      if (sdram_cmd == CMD_RD)
      begin
        if (idx >= n_ops || !rd_req)
        begin
          $display("RD command issued while no read request was held");
          tb_errs++;
        end
        else
        begin
          slot_vld[CL] = 1'b1;
          slot_dq[CL]  = tr_data[idx];
          exp_stb      = 1'b1;
          exp_rdata    = tr_data[idx];
        end
      end
      sdram_dq = slot_vld[0] ? slot_dq[0] : 16'hdead;
      if (req_rdy && idx < n_ops)
      begin
        exp_ba    = tr_ba[idx];
        exp_row   = tr_row[idx];
        exp_col   = tr_col[idx];
        exp_wdata = tr_data[idx];
        idx++;
      end
      drive_request();
    end
  end

  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt > limit)
    begin
      $display("Timeout after %0d cycles with %0d of %0d requests served", cyc_cnt, idx, n_ops);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial
  begin
    rst_ni    = 1'b0;
    rd_req    = 1'b0;
    wr_req    = 1'b0;
    req_ba    = '0;
    req_row   = '0;
    req_col   = '0;
    wr_data   = '0;
    sdram_dq  = 16'hdead;
    exp_stb   = 1'b0;
    exp_rdata = '0;
    exp_ba    = '0;
    exp_row   = '0;
    exp_col   = '0;
    exp_wdata = '0;
    tb_errs   = 0;
    idx       = 0;
    cyc_cnt   = 0;
    for (int i = 0; i <= CL; i++)
    begin
      slot_vld[i] = 1'b0;
      slot_dq[i]  = '0;
    end
    load_trace();
    limit = n_ops * (T_RP + T_RCD + T_RAS + CL + 8) + 2 * T_REFI + 10;
    if (n_ops == 0)
    begin
      $display("The trace holds no requests");
      tb_errs++;
    end

    repeat (10) @(negedge clk);
    rst_ni <= 1'b1;
    wait (idx >= n_ops);
    // Idle long enough for at least one refresh
    repeat (TAIL) @(negedge clk);

    if (ref_cnt == 0)
    begin
      $display("No refresh was seen during the run");
      tb_errs++;
    end
    if (rd_cnt != n_rd)
    begin
      $display("Only %0d of %0d reads returned data", rd_cnt, n_rd);
      tb_errs++;
    end
    $display("Checker errors %0d, testbench errors %0d, reads %0d, refreshes %0d",
             chk_errs, tb_errs, rd_cnt, ref_cnt);
    if (chk_errs == 0 && tb_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/sched_trace.txt ====
# op bank row col data, all hex
# W data goes to the DUT, R data is returned on DQ after CL
W 0 010 04 a001
R 0 010 04 b001
R 0 010 05 b002
R 0 010 06 b003
W 1 020 00 a002
R 1 020 01 b004
R 0 011 07 b005
W 0 011 08 a003
W 2 7ff ff a004
R 2 7ff fe b006
R 2 7ff fd b007
R 3 155 10 b008
W 3 2aa 11 a005
R 3 2aa 12 b009
R 1 020 02 b00a
R 1 020 03 b00b

// ==== build.f ====
design/sdram_geom_pkg.sv
design/sdram_cmd_pkg.sv
design/sdram_timer_if.sv
design/sdram_bank_timers.sv
design/sdram_refresh_ctrl.sv
design/sdram_cmd_fsm.sv
design/sdram_rd_tracker.sv
design/sdram_sched_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

T_RCD  ?= 3
T_RP   ?= 3
T_RAS  ?= 6
T_RC   ?= 8
T_REFI ?= 200
CL     ?= 2

PARAMS = -GT_RCD=$(T_RCD) -GT_RP=$(T_RP) -GT_RAS=$(T_RAS) \
         -GT_RC=$(T_RC) -GT_REFI=$(T_REFI) -GCL=$(CL)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
